// File: design/decode_pkg.sv
`default_nettype none

package decode_pkg;

   localparam int word_w     = 32;
   localparam int reg_addr_w = 5;
   localparam int num_regs   = 1 << reg_addr_w;
   localparam int op_w       = 6;
   localparam int funct_w    = 6;
   localparam int imm_w      = 16;
   localparam int index_w    = 26;  // jump index field
   localparam int shamt_lsb  = 6;
   localparam int rd_lsb     = 11;
   localparam int rt_lsb     = 16;
   localparam int rs_lsb     = 21;

   typedef logic [word_w-1:0]     word_t;
   typedef logic [reg_addr_w-1:0] reg_idx_t;

   // standard MIPS major opcodes
   typedef enum logic [op_w-1:0] {
      op_special = 6'd0,
      op_j       = 6'd2,
      op_jal     = 6'd3,
      op_beq     = 6'd4,
      op_bne     = 6'd5,
      op_addi    = 6'd8,
      op_slti    = 6'd10,
      op_andi    = 6'd12,
      op_ori     = 6'd13,
      op_xori    = 6'd14,
      op_lui     = 6'd15,
      op_lb      = 6'd32,
      op_lh      = 6'd33,
      op_lw      = 6'd35,
      op_lbu     = 6'd36,
      op_lhu     = 6'd37,
      op_lwu     = 6'd39,
      op_sb      = 6'd40,
      op_sh      = 6'd41,
      op_sw      = 6'd43
   } opcode_e;

   // special group functions the decoder cares about
   typedef enum logic [funct_w-1:0] {
      fn_sll  = 6'd0,
      fn_srl  = 6'd2,
      fn_sra  = 6'd3,
      fn_jr   = 6'd8,
      fn_jalr = 6'd9
   } funct_e;

   typedef enum logic [3:0] {
      alu_none, alu_add, alu_slti, alu_andi, alu_ori, alu_xori, alu_lui, alu_jal,
      alu_func  // execute stage looks at funct
   } alu_op_e;

   typedef enum logic [1:0] {ext_jmp, ext_sgn, ext_zro, ext_spc} ext_mode_e;
   typedef enum logic [1:0] {src_a_pc, src_a_rs, src_a_ext, src_a_none} src_a_e;
   typedef enum logic       {src_b_rt, src_b_ext} src_b_e;
   typedef enum logic [1:0] {dest_rd, dest_rt, dest_r31} dest_sel_e;

   typedef enum logic [1:0] {mem_rd_none, mem_rd_byte, mem_rd_half, mem_rd_word} mem_rd_e;
   typedef enum logic [1:0] {mem_wr_none, mem_wr_byte, mem_wr_half, mem_wr_word} mem_wr_e;
   typedef enum logic [1:0] {wb_alu, wb_mem, wb_sign_byte, wb_sign_half} wb_sel_e;

   typedef struct packed {
      alu_op_e   alu_op;
      src_a_e    src_a;
      dest_sel_e dest_sel;
      src_b_e    src_b;
   } exec_ctrl_t;

   typedef struct packed {
      mem_rd_e rd;
      mem_wr_e wr;
   } mem_ctrl_t;

   typedef struct packed {
      logic    we;
      wb_sel_e sel;
   } wb_ctrl_t;

   // consumed in decode only, never latched
   typedef struct packed {
      logic beq;
      logic bne;
      logic jump;
      logic reg_jump;
   } flow_ctrl_t;

   typedef struct packed {
      word_t              pc;
      word_t              rs_val;
      word_t              rt_val;
      word_t              ext;
      logic [funct_w-1:0] funct;
      reg_idx_t           rs;
      reg_idx_t           rt;
      reg_idx_t           rd;
      exec_ctrl_t         exec;
      mem_ctrl_t          mem;
      wb_ctrl_t           wb;
   } id_ex_t;

endpackage

`default_nettype wire

// File: design/control_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module control_decoder (
   input  decode_pkg::word_t      i_instr,
   output decode_pkg::exec_ctrl_t o_exec,
   output decode_pkg::mem_ctrl_t  o_mem,
   output decode_pkg::wb_ctrl_t   o_wb,
   output decode_pkg::flow_ctrl_t o_flow,
   output decode_pkg::word_t      o_ext
);

   decode_pkg::ext_mode_e             ext_mode;
   logic [decode_pkg::op_w-1:0]       opcode;
   logic [decode_pkg::funct_w-1:0]    funct;
   logic                              is_reg_jump;

   assign opcode      = i_instr[decode_pkg::word_w-1 -: decode_pkg::op_w];
   assign funct       = i_instr[decode_pkg::funct_w-1:0];
   assign is_reg_jump = (funct == decode_pkg::fn_jr) || (funct == decode_pkg::fn_jalr);

   always_comb begin
      // no-op defaults where HALT and unknown opcodes stay
      ext_mode        = decode_pkg::ext_sgn;
      o_exec.alu_op   = decode_pkg::alu_none;
      o_exec.src_a    = decode_pkg::src_a_none;
      o_exec.dest_sel = decode_pkg::dest_rd;
      o_exec.src_b    = decode_pkg::src_b_ext;
      o_mem.rd        = decode_pkg::mem_rd_none;
      o_mem.wr        = decode_pkg::mem_wr_none;
      o_wb.we         = 1'b0;
      o_wb.sel        = decode_pkg::wb_alu;
      o_flow          = '0;
      case (opcode)
         decode_pkg::op_j: begin
            ext_mode    = decode_pkg::ext_jmp;
            o_flow.jump = 1'b1;
         end
         decode_pkg::op_jal: begin
            ext_mode        = decode_pkg::ext_jmp;
            o_exec.alu_op   = decode_pkg::alu_jal;  // link value built from pc
            o_exec.src_a    = decode_pkg::src_a_pc;
            o_exec.dest_sel = decode_pkg::dest_r31;
            o_flow.jump     = 1'b1;
            o_wb.we         = 1'b1;
         end
         decode_pkg::op_beq: o_flow.beq = 1'b1;
         decode_pkg::op_bne: o_flow.bne = 1'b1;
         decode_pkg::op_addi, decode_pkg::op_slti, decode_pkg::op_andi,
         decode_pkg::op_ori, decode_pkg::op_xori, decode_pkg::op_lui: begin
            o_exec.src_a    = decode_pkg::src_a_rs;
            o_exec.dest_sel = decode_pkg::dest_rt;
            o_wb.we         = 1'b1;
            if (opcode != decode_pkg::op_addi && opcode != decode_pkg::op_slti) begin
               ext_mode = decode_pkg::ext_zro;  // logical ops and lui
            end
            case (opcode)
               decode_pkg::op_addi: o_exec.alu_op = decode_pkg::alu_add;
               decode_pkg::op_slti: o_exec.alu_op = decode_pkg::alu_slti;
               decode_pkg::op_andi: o_exec.alu_op = decode_pkg::alu_andi;
               decode_pkg::op_ori:  o_exec.alu_op = decode_pkg::alu_ori;
               decode_pkg::op_xori: o_exec.alu_op = decode_pkg::alu_xori;
               default: begin
                  o_exec.alu_op = decode_pkg::alu_lui;
                  o_exec.src_a  = decode_pkg::src_a_none;
               end
            endcase
         end
         decode_pkg::op_lb, decode_pkg::op_lh, decode_pkg::op_lw,
         decode_pkg::op_lbu, decode_pkg::op_lhu, decode_pkg::op_lwu,
         decode_pkg::op_sb, decode_pkg::op_sh, decode_pkg::op_sw: begin
            o_exec.alu_op   = decode_pkg::alu_add;  // base + offset
            o_exec.src_a    = decode_pkg::src_a_rs;
            o_exec.dest_sel = decode_pkg::dest_rt;
            o_wb.sel        = decode_pkg::wb_mem;
            o_wb.we         = ~opcode[3];  // stores sit at 40..43
            case (opcode)
               decode_pkg::op_lb: begin
                  o_mem.rd = decode_pkg::mem_rd_byte;
                  o_wb.sel = decode_pkg::wb_sign_byte;
               end
               decode_pkg::op_lh: begin
                  o_mem.rd = decode_pkg::mem_rd_half;
                  o_wb.sel = decode_pkg::wb_sign_half;
               end
               decode_pkg::op_lbu:                    o_mem.rd = decode_pkg::mem_rd_byte;
               decode_pkg::op_lhu:                    o_mem.rd = decode_pkg::mem_rd_half;
               decode_pkg::op_lw, decode_pkg::op_lwu: o_mem.rd = decode_pkg::mem_rd_word;
               decode_pkg::op_sb:                     o_mem.wr = decode_pkg::mem_wr_byte;
               decode_pkg::op_sh:                     o_mem.wr = decode_pkg::mem_wr_half;
               default:                               o_mem.wr = decode_pkg::mem_wr_word;
            endcase
         end
         decode_pkg::op_special: begin
            ext_mode      = decode_pkg::ext_spc;
            o_exec.alu_op = decode_pkg::alu_func;
            o_exec.src_b  = decode_pkg::src_b_rt;
            case (funct)
               decode_pkg::fn_jalr: o_exec.src_a = decode_pkg::src_a_pc;
               decode_pkg::fn_sll, decode_pkg::fn_srl, decode_pkg::fn_sra:
                  o_exec.src_a = decode_pkg::src_a_ext;  // shamt into A
               default: o_exec.src_a = decode_pkg::src_a_rs;
            endcase
            o_flow.jump     = is_reg_jump;
            o_flow.reg_jump = is_reg_jump;
            // zero funct counts as the nop and never writes
            o_wb.we = !(funct == decode_pkg::fn_jr || funct == '0);
         end
         default: ;
      endcase
   end

   // immediate extension
   always_comb begin
      case (ext_mode)
         decode_pkg::ext_jmp:
            o_ext = {{(decode_pkg::word_w-decode_pkg::index_w){1'b0}},
                     i_instr[decode_pkg::index_w-1:0]};
         decode_pkg::ext_sgn:
            o_ext = {{(decode_pkg::word_w-decode_pkg::imm_w){i_instr[decode_pkg::imm_w-1]}},
                     i_instr[decode_pkg::imm_w-1:0]};
         decode_pkg::ext_zro:
            o_ext = {{(decode_pkg::word_w-decode_pkg::imm_w){1'b0}},
                     i_instr[decode_pkg::imm_w-1:0]};
         decode_pkg::ext_spc:
            o_ext = {{(decode_pkg::word_w-decode_pkg::reg_addr_w){1'b0}},
                     i_instr[decode_pkg::shamt_lsb +: decode_pkg::reg_addr_w]};
      endcase
   end

endmodule

`default_nettype wire

// File: design/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  decode_pkg::reg_idx_t i_rs_addr,
   input  decode_pkg::reg_idx_t i_rt_addr,
   input  decode_pkg::reg_idx_t i_wr_addr,
   input  decode_pkg::word_t    i_wr_data,
   input  logic                 i_wr_en,
   output decode_pkg::word_t    o_rs,
   output decode_pkg::word_t    o_rt,
   output logic                 o_equal
);

   decode_pkg::word_t regs [decode_pkg::num_regs];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < decode_pkg::num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wr_en && i_wr_addr != '0) begin  // $zero is read-only
         regs[i_wr_addr] <= i_wr_data;
      end
   end

   // async reads with no same-cycle write bypass
   assign o_rs = (i_rs_addr == '0) ? '0 : regs[i_rs_addr];
   assign o_rt = (i_rt_addr == '0) ? '0 : regs[i_rt_addr];

   assign o_equal = (o_rs == o_rt);  // beq/bne compare

endmodule

`default_nettype wire

// File: design/branch_resolver.sv
`timescale 1ns/1ps
`default_nettype none

module branch_resolver (
   input  decode_pkg::flow_ctrl_t i_flow,
   input  decode_pkg::word_t      i_pc,
   input  decode_pkg::word_t      i_ext,
   input  decode_pkg::word_t      i_rs,
   input  logic                   i_equal,
   output decode_pkg::word_t      o_brh_addr,
   output decode_pkg::word_t      o_jmp_addr,
   output logic                   o_branch_taken,
   output logic                   o_pc_src,
   output logic                   o_flush,
   output logic                   o_is_branch,
   output logic                   o_is_reg_jump
);

   logic taken;

   // offset is relative to the pc of this instruction
   assign o_brh_addr = i_pc + (i_ext << 2);

   // jr/jalr take rs, j/jal stay in the current 256 MB region
   assign o_jmp_addr = i_flow.reg_jump ? i_rs :
                       {i_pc[decode_pkg::word_w-1:decode_pkg::index_w+2],
                        i_ext[decode_pkg::index_w-1:0], 2'b00};

   assign taken = (i_flow.beq & i_equal) | (i_flow.bne & ~i_equal);

   assign o_branch_taken = taken;
   assign o_pc_src       = i_flow.jump;
   assign o_flush        = taken | i_flow.jump;  // kill the fetched slot
   assign o_is_branch    = i_flow.beq | i_flow.bne;
   assign o_is_reg_jump  = i_flow.reg_jump;

endmodule

`default_nettype wire

// File: design/id_ex_register.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_register (
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_bubble,
   input  decode_pkg::id_ex_t i_stage,
   output decode_pkg::id_ex_t o_stage
);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_stage <= '0;
      end else begin
         o_stage <= i_stage;
         if (i_bubble) begin
            // control goes idle while data and indices still move
            o_stage.exec <= '0;
            o_stage.mem  <= '0;
            o_stage.wb   <= '0;
         end
      end
   end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  decode_pkg::word_t    i_pc,
   input  decode_pkg::word_t    i_instr,
   input  decode_pkg::word_t    i_wb_data,
   input  decode_pkg::reg_idx_t i_wb_addr,
   input  logic                 i_wb_we,
   input  logic                 i_bubble,
   output decode_pkg::id_ex_t   o_id_ex,
   output decode_pkg::word_t    o_brh_addr,
   output decode_pkg::word_t    o_jmp_addr,
   output logic                 o_branch_taken,
   output logic                 o_pc_src,
   output logic                 o_flush,
   output logic                 o_is_branch,
   output logic                 o_is_reg_jump
);

   decode_pkg::exec_ctrl_t exec;
   decode_pkg::mem_ctrl_t  mem;
   decode_pkg::wb_ctrl_t   wb;
   decode_pkg::flow_ctrl_t flow;
   decode_pkg::word_t      ext;
   decode_pkg::word_t      rs_val;
   decode_pkg::word_t      rt_val;
   decode_pkg::reg_idx_t   rs;
   decode_pkg::reg_idx_t   rt;
   decode_pkg::reg_idx_t   rd;
   logic                   equal;
   decode_pkg::id_ex_t     stage_d;

   // instruction fields
   assign rs = i_instr[decode_pkg::rs_lsb +: decode_pkg::reg_addr_w];
   assign rt = i_instr[decode_pkg::rt_lsb +: decode_pkg::reg_addr_w];
   assign rd = i_instr[decode_pkg::rd_lsb +: decode_pkg::reg_addr_w];

   control_decoder u_control_decoder (
      .i_instr (i_instr),
      .o_exec  (exec),
      .o_mem   (mem),
      .o_wb    (wb),
      .o_flow  (flow),
      .o_ext   (ext)
   );

   register_file u_register_file (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_rs_addr (rs),
      .i_rt_addr (rt),
      .i_wr_addr (i_wb_addr),
      .i_wr_data (i_wb_data),
      .i_wr_en   (i_wb_we),
      .o_rs      (rs_val),
      .o_rt      (rt_val),
      .o_equal   (equal)
   );

   branch_resolver u_branch_resolver (
      .i_flow         (flow),
      .i_pc           (i_pc),
      .i_ext          (ext),
      .i_rs           (rs_val),
      .i_equal        (equal),
      .o_brh_addr     (o_brh_addr),
      .o_jmp_addr     (o_jmp_addr),
      .o_branch_taken (o_branch_taken),
      .o_pc_src       (o_pc_src),
      .o_flush        (o_flush),
      .o_is_branch    (o_is_branch),
      .o_is_reg_jump  (o_is_reg_jump)
   );

   assign stage_d = '{
      pc:     i_pc,
      rs_val: rs_val,
      rt_val: rt_val,
      ext:    ext,
      funct:  i_instr[decode_pkg::funct_w-1:0],
      rs:     rs,
      rt:     rt,
      rd:     rd,
      exec:   exec,
      mem:    mem,
      wb:     wb
   };

   id_ex_register u_id_ex_register (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_bubble (i_bubble),
      .i_stage  (stage_d),
      .o_stage  (o_id_ex)
   );

endmodule

`default_nettype wire

// File: include/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected extended immediate with the mode picked straight from the opcode
function automatic decode_pkg::word_t model_ext(input decode_pkg::word_t instr);
   logic [5:0] op;
   op = instr[31:26];
   if (op inside {decode_pkg::op_j, decode_pkg::op_jal}) return {6'b0, instr[25:0]};
   if (op == decode_pkg::op_special) return {27'b0, instr[10:6]};
   if (op inside {decode_pkg::op_andi, decode_pkg::op_ori, decode_pkg::op_xori,
                  decode_pkg::op_lui}) return {16'b0, instr[15:0]};
   return {{16{instr[15]}}, instr[15:0]};
endfunction

// expected control words built field by field
function automatic void model_ctrl(input decode_pkg::word_t instr,
                                   output decode_pkg::exec_ctrl_t exec,
                                   output decode_pkg::mem_ctrl_t mem,
                                   output decode_pkg::wb_ctrl_t wb,
                                   output decode_pkg::flow_ctrl_t flow);
   logic [5:0] op;
   logic [5:0] fn;
   logic       is_ld;
   logic       is_st;
   logic       is_spc;
   logic       rjmp;
   op     = instr[31:26];
   fn     = instr[5:0];
   is_ld  = op inside {6'd32, 6'd33, 6'd35, 6'd36, 6'd37, 6'd39};
   is_st  = op inside {6'd40, 6'd41, 6'd43};
   is_spc = (op == 6'd0);
   rjmp   = is_spc && fn inside {6'd8, 6'd9};
   exec.alu_op   = decode_pkg::alu_none;
   exec.src_a    = decode_pkg::src_a_none;
   exec.dest_sel = decode_pkg::dest_rd;
   exec.src_b    = is_spc ? decode_pkg::src_b_rt : decode_pkg::src_b_ext;
   case (op)
      6'd3:  exec.alu_op = decode_pkg::alu_jal;
      6'd8:  exec.alu_op = decode_pkg::alu_add;
      6'd10: exec.alu_op = decode_pkg::alu_slti;
      6'd12: exec.alu_op = decode_pkg::alu_andi;
      6'd13: exec.alu_op = decode_pkg::alu_ori;
      6'd14: exec.alu_op = decode_pkg::alu_xori;
      6'd15: exec.alu_op = decode_pkg::alu_lui;
      6'd0:  exec.alu_op = decode_pkg::alu_func;
      default: if (is_ld || is_st) exec.alu_op = decode_pkg::alu_add;
   endcase
   if (op == 6'd3 || (is_spc && fn == 6'd9)) exec.src_a = decode_pkg::src_a_pc;
   else if (is_spc && fn inside {6'd0, 6'd2, 6'd3}) exec.src_a = decode_pkg::src_a_ext;
   else if (is_spc || is_ld || is_st || op inside {6'd8, 6'd10, [6'd12:6'd14]})
      exec.src_a = decode_pkg::src_a_rs;
   if (op == 6'd3) exec.dest_sel = decode_pkg::dest_r31;
   else if (is_ld || is_st || op inside {6'd8, 6'd10, [6'd12:6'd15]})
      exec.dest_sel = decode_pkg::dest_rt;
   mem.rd = is_ld ? decode_pkg::mem_rd_e'(op[1:0] == 2'b11 ? 2'd3 : op[1:0] + 2'd1)
                  : decode_pkg::mem_rd_none;
   mem.wr = is_st ? decode_pkg::mem_wr_e'(op[1:0] == 2'b11 ? 2'd3 : op[1:0] + 2'd1)
                  : decode_pkg::mem_wr_none;
   wb.sel = decode_pkg::wb_alu;
   if (op == 6'd32) wb.sel = decode_pkg::wb_sign_byte;
   else if (op == 6'd33) wb.sel = decode_pkg::wb_sign_half;
   else if (is_ld || is_st) wb.sel = decode_pkg::wb_mem;
   wb.we = is_ld || op == 6'd3 || op inside {6'd8, 6'd10, [6'd12:6'd15]}
           || is_spc && !(fn == 6'd8 || fn == 6'd0);
   flow.beq      = (op == 6'd4);
   flow.bne      = (op == 6'd5);
   flow.jump     = op inside {6'd2, 6'd3} || rjmp;
   flow.reg_jump = rjmp;
endfunction

function automatic decode_pkg::word_t model_brh_addr(input decode_pkg::word_t pc, ext);
   return pc + {ext[29:0], 2'b00};
endfunction

function automatic decode_pkg::word_t model_jmp_addr(input decode_pkg::word_t pc, ext, rs,
                                                     input logic rjmp);
   return rjmp ? rs : {pc[31:28], ext[25:0], 2'b00};
endfunction

`endif

// File: dv/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

   localparam int reset_cycles  = 10;
   localparam int n_random      = 400;
   // reset, register sweep, random run, directed branches and jumps, tail
   localparam int test_cycles   = reset_cycles + 2 * decode_pkg::num_regs + n_random + 24;
   localparam int timeout_limit = test_cycles + 50;

   // decoded opcodes first, then four that fall to the no-op default
   localparam logic [5:0] op_pool [24] = '{
      6'd0, 6'd2, 6'd3, 6'd4, 6'd5, 6'd8, 6'd10, 6'd12, 6'd13, 6'd14, 6'd15, 6'd32,
      6'd33, 6'd35, 6'd36, 6'd37, 6'd39, 6'd40, 6'd41, 6'd43, 6'd1, 6'd9, 6'd11, 6'd63};
   localparam logic [5:0] fn_pool [8] = '{6'd0, 6'd2, 6'd3, 6'd8, 6'd9, 6'd32, 6'd34, 6'd42};

   logic                 i_clk;
   logic                 i_rst;
   decode_pkg::word_t    i_pc;
   decode_pkg::word_t    i_instr;
   decode_pkg::word_t    i_wb_data;
   decode_pkg::reg_idx_t i_wb_addr;
   logic                 i_wb_we;
   logic                 i_bubble;
   decode_pkg::id_ex_t   o_id_ex;
   decode_pkg::word_t    o_brh_addr;
   decode_pkg::word_t    o_jmp_addr;
   logic                 o_branch_taken;
   logic                 o_pc_src;
   logic                 o_flush;
   logic                 o_is_branch;
   logic                 o_is_reg_jump;

   decode_pkg::word_t shadow [decode_pkg::num_regs] = '{default: '0};  // expected reg contents
   logic [31:0]       rng_state = 32'h836d_7229;
   int                cycles = 0;

   `include "decode_model.svh"

   decode_stage i_decode_stage (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_pc           (i_pc),
      .i_instr        (i_instr),
      .i_wb_data      (i_wb_data),
      .i_wb_addr      (i_wb_addr),
      .i_wb_we        (i_wb_we),
      .i_bubble       (i_bubble),
      .o_id_ex        (o_id_ex),
      .o_brh_addr     (o_brh_addr),
      .o_jmp_addr     (o_jmp_addr),
      .o_branch_taken (o_branch_taken),
      .o_pc_src       (o_pc_src),
      .o_flush        (o_flush),
      .o_is_branch    (o_is_branch),
      .o_is_reg_jump  (o_is_reg_jump)
   );

   initial begin
      i_clk = 1'b0;
      forever #10 i_clk = ~i_clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [31:0] random_word();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic decode_pkg::word_t imm_instr(input logic [5:0] op, input int rs, rt,
                                                   input logic [15:0] imm);
      return {op, rs[4:0], rt[4:0], imm};
   endfunction

   function automatic decode_pkg::word_t reg_instr(input int rs, rt, rd, input logic [5:0] fn);
      return {6'd0, rs[4:0], rt[4:0], rd[4:0], 5'd3, fn};  // shamt fixed at 3
   endfunction

   function automatic decode_pkg::word_t jump_instr(input logic [5:0] op,
                                                    input logic [25:0] index);
      return {op, index};
   endfunction

   function automatic decode_pkg::word_t random_instr();
      logic [31:0] r;
      logic [5:0]  op;
      int          idx;
      r   = random_word();
      idx = int'(r[31:27]) % 24;
      op  = op_pool[idx];
      r   = random_word();
      if (op == 6'd0 && r[31]) begin
         return {op, r[25:6], fn_pool[r[30:28]]};  // bias toward jr/jalr and shifts
      end
      return {op, r[25:0]};
   endfunction

   function automatic decode_pkg::word_t shadow_read(input decode_pkg::reg_idx_t idx);
      return (idx == '0) ? '0 : shadow[idx];
   endfunction

   // expected ID/EX contents one edge after pc and instr are presented
   function automatic decode_pkg::id_ex_t predict_stage(input decode_pkg::word_t pc, instr,
                                                         input logic bubble);
      decode_pkg::id_ex_t     s;
      decode_pkg::exec_ctrl_t exec;
      decode_pkg::mem_ctrl_t  mem;
      decode_pkg::wb_ctrl_t   wb;
      decode_pkg::flow_ctrl_t flow;
      model_ctrl(instr, exec, mem, wb, flow);
      s.pc     = pc;
      s.rs_val = shadow_read(instr[25:21]);
      s.rt_val = shadow_read(instr[20:16]);
      s.ext    = model_ext(instr);
      s.funct  = instr[5:0];
      s.rs     = instr[25:21];
      s.rt     = instr[20:16];
      s.rd     = instr[15:11];
      s.exec   = exec;
      s.mem    = mem;
      s.wb     = wb;
      if (bubble) begin
         s.exec = '0;
         s.mem  = '0;
         s.wb   = '0;
      end
      return s;
   endfunction

   task automatic halt_with_failure();
      $display("=== FAIL ===");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic match_stage(input string name, input decode_pkg::id_ex_t got, exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         halt_with_failure();
      end
   endtask

   task automatic compare_word(input string name, input decode_pkg::word_t got, exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         halt_with_failure();
      end
   endtask

   task automatic expect_bit(input string name, input logic got, exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
         halt_with_failure();
      end
   endtask

   // same-cycle branch and jump outputs against the model
   task automatic verify_branch_outputs();
      decode_pkg::exec_ctrl_t exec;
      decode_pkg::mem_ctrl_t  mem;
      decode_pkg::wb_ctrl_t   wb;
      decode_pkg::flow_ctrl_t flow;
      decode_pkg::word_t      ext;
      decode_pkg::word_t      rs_val;
      logic                   equal;
      logic                   taken;
      model_ctrl(i_instr, exec, mem, wb, flow);
      ext    = model_ext(i_instr);
      rs_val = shadow_read(i_instr[25:21]);
      equal  = (rs_val == shadow_read(i_instr[20:16]));
      taken  = (flow.beq && equal) || (flow.bne && !equal);
      compare_word("o_brh_addr", o_brh_addr, model_brh_addr(i_pc, ext));
      compare_word("o_jmp_addr", o_jmp_addr, model_jmp_addr(i_pc, ext, rs_val, flow.reg_jump));
      expect_bit("o_branch_taken", o_branch_taken, taken);
      expect_bit("o_pc_src", o_pc_src, flow.jump);
      expect_bit("o_flush", o_flush, taken || flow.jump);
      expect_bit("o_is_branch", o_is_branch, flow.beq || flow.bne);
      expect_bit("o_is_reg_jump", o_is_reg_jump, flow.reg_jump);
   endtask

   task automatic drive_cycle(input decode_pkg::word_t pc, instr, input logic we,
                              input decode_pkg::reg_idx_t addr, input decode_pkg::word_t data,
                              input logic bubble);
      @(negedge i_clk);
      i_pc      = pc;
      i_instr   = instr;
      i_wb_we   = we;
      i_wb_addr = addr;
      i_wb_data = data;
      i_bubble  = bubble;
   endtask

   task automatic run_instr(input decode_pkg::word_t pc, instr, input logic bubble);
      drive_cycle(pc, instr, 1'b0, '0, '0, bubble);
   endtask

   task automatic write_reg(input decode_pkg::word_t pc, input int addr,
                            input decode_pkg::word_t data);
      drive_cycle(pc, '0, 1'b1, decode_pkg::reg_idx_t'(addr), data, 1'b0);
   endtask

   // inputs settle at the falling edge, so sample them at the rising one
   initial begin : compare_outputs
      decode_pkg::id_ex_t exp_stage;
      forever begin
         @(posedge i_clk);
         verify_branch_outputs();
         if (i_rst) begin
            exp_stage = '0;
            foreach (shadow[k]) shadow[k] = '0;
         end else begin
            exp_stage = predict_stage(i_pc, i_instr, i_bubble);
            if (i_wb_we && i_wb_addr != '0) shadow[i_wb_addr] = i_wb_data;
         end
         @(negedge i_clk);
         match_stage("o_id_ex", o_id_ex, exp_stage);
      end
   end

   always @(posedge i_clk) begin
      cycles++;
      if (cycles >= timeout_limit) begin
         $display("Timeout: the test did not finish within %0d cycles", timeout_limit);
         halt_with_failure();
      end
   end

   initial begin : stimulus
      decode_pkg::word_t pc;
      logic [31:0]       r;
      i_rst     = 1'b1;
      i_pc      = '0;
      i_instr   = '0;
      i_wb_data = '0;
      i_wb_addr = '0;
      i_wb_we   = 1'b0;
      i_bubble  = 1'b0;
      pc        = 32'h0040_0000;
      repeat (reset_cycles) @(posedge i_clk);
      @(negedge i_clk);
      i_rst = 1'b0;
      match_stage("o_id_ex", o_id_ex, '0);  // fresh out of reset
      expect_bit("o_branch_taken", o_branch_taken, 1'b0);
      expect_bit("o_pc_src", o_pc_src, 1'b0);
      expect_bit("o_flush", o_flush, 1'b0);
      expect_bit("o_is_branch", o_is_branch, 1'b0);
      expect_bit("o_is_reg_jump", o_is_reg_jump, 1'b0);

      // fill every register, $zero included, then read them all back
      for (int k = 0; k < decode_pkg::num_regs; k++) begin
         write_reg(pc, k, random_word() | 32'h1);
      end
      for (int k = 0; k < decode_pkg::num_regs; k++) begin
         pc += 4;
         run_instr(pc, reg_instr(k, decode_pkg::num_regs - 1 - k, k, 6'd32), 1'b0);
      end

      for (int k = 0; k < n_random; k++) begin
         r  = random_word();
         pc = random_word() & 32'hffff_fffc;
         drive_cycle(pc, random_instr(), r[0], r[5:1], random_word(), r[8:6] == 3'b000);
      end

      // r5 == r6, r7 differs
      write_reg(pc, 5, 32'h1234_5678);
      write_reg(pc, 6, 32'h1234_5678);
      write_reg(pc, 7, 32'h8765_4321);
      pc = 32'h0040_1000;
      run_instr(pc, imm_instr(6'd4, 5, 6, 16'h0010), 1'b0);
      run_instr(pc + 4, imm_instr(6'd4, 5, 7, 16'hfff0), 1'b0);
      run_instr(pc + 8, imm_instr(6'd5, 5, 6, 16'h0020), 1'b0);
      run_instr(pc + 12, imm_instr(6'd5, 5, 7, 16'h8000), 1'b0);
      run_instr(pc + 16, imm_instr(6'd4, 0, 0, 16'hfffe), 1'b1);  // taken, bubbled
      run_instr(pc + 20, imm_instr(6'd35, 5, 7, 16'h0004), 1'b1);

      pc = 32'hb000_2000;
      run_instr(pc, jump_instr(6'd2, 26'h123_4567), 1'b0);
      run_instr(pc + 4, jump_instr(6'd3, 26'h3ff_fffc), 1'b0);
      run_instr(pc + 8, reg_instr(5, 0, 0, 6'd8), 1'b0);
      expect_bit("o_id_ex.wb.we", o_id_ex.wb.we, 1'b1);  // jal now in ID/EX
      expect_bit("o_id_ex.exec.dest_sel is r31",
                 o_id_ex.exec.dest_sel == decode_pkg::dest_r31, 1'b1);
      run_instr(pc + 12, reg_instr(7, 0, 31, 6'd9), 1'b0);
      run_instr(pc + 16, '0, 1'b0);

      repeat (2) @(posedge i_clk);
      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
design/decode_pkg.sv
design/control_decoder.sv
design/register_file.sv
design/branch_resolver.sv
design/id_ex_register.sv
design/decode_stage.sv
dv/decode_stage_tb.sv

// File: Makefile
# Verilator flow for the decode stage

VERILATOR ?= verilator
FILELIST  ?= compile.f
TOP       ?= decode_stage_tb
RTL_TOP   ?= decode_stage
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= === PASS ===

SOURCES  := $(filter %.sv,$(shell cat $(FILELIST)))
RTL_SRCS := $(filter design/%,$(SOURCES))
HEADERS  := $(wildcard include/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF -- "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
